// ==== Makefile ====
TOP := tb_l2_prefetch

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "Simulation failed" >> sim.log
	@cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
source/pref_pkg.sv
source/l2_cfg_pkg.sv
source/pref_if.sv
source/addr_lfsr.sv
source/prefetch_issuer.sv
source/l2_tag_store.sv
source/l2_prefetch_top.sv
verif/tb_l2_prefetch.sv

// ==== source/addr_lfsr.sv ====
`timescale 1ns/10ps

module addr_lfsr #(
    parameter int          ADDR_WIDTH = 32,
    parameter logic [31:0] LFSR_SEED  = 32'd1
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  step,
    output logic [ADDR_WIDTH-1:0] addr
);
    import l2_cfg_pkg::*;

    logic [31:0] state;
    logic        feedback;

    // taps 32, 22, 2, 1
    assign feedback = state[31] ^ state[21] ^ state[1] ^ state[0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= LFSR_SEED;
        end else if (step) begin
            state <= {state[30:0], feedback};
        end
    end

    // line aligned
    assign addr = {state[ADDR_WIDTH-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};

    // all-zero state would lock up the sequence
    a_state_nonzero: assert property (@(posedge clk) disable iff (!rstn) state != '0);

endmodule

// ==== source/l2_cfg_pkg.sv ====
package l2_cfg_pkg;

    // --------------------------------------------------
    // L2 geometry
    // --------------------------------------------------

    // 32-byte lines
    localparam int LINE_OFFSET_BITS = 5;

    // address splits as tag | index (SET_BITS wide) | line offset
    function automatic int tag_bits(input int addr_width, input int set_bits);
        return addr_width - set_bits - LINE_OFFSET_BITS;
    endfunction

    // sets per bank
    function automatic int num_sets(input int set_bits);
        return 1 << set_bits;
    endfunction

endpackage

// ==== source/l2_prefetch_top.sv ====
`timescale 1ns/10ps

module l2_prefetch_top #(
    parameter int          ADDR_WIDTH = 32,
    parameter int          SET_BITS   = 3,
    parameter int          MAX_GAP    = 10,
    parameter logic [31:0] LFSR_SEED  = 32'd1
) (
    input  logic                  clk,
    input  logic                  rstn,
    // wishbone demand read port
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic [ADDR_WIDTH-1:0] wb_adr,
    input  pref_pkg::pref_kind_e  wb_kind,
    output logic                  wb_ack,
    output logic                  wb_dat,
    // prefetch observation
    output logic                  pref_valid,
    output pref_pkg::pref_kind_e  pref_kind,
    output logic [ADDR_WIDTH-1:0] pref_addr,
    output logic                  pref_done,
    output logic                  pref_hit
);
    logic                  lfsr_step;
    logic [ADDR_WIDTH-1:0] lfsr_addr;

    pref_if #(.ADDR_WIDTH(ADDR_WIDTH)) pif ();

    addr_lfsr #(.ADDR_WIDTH(ADDR_WIDTH), .LFSR_SEED(LFSR_SEED)) u_lfsr (
        .clk(clk), .rstn(rstn), .step(lfsr_step), .addr(lfsr_addr)
    );

    prefetch_issuer #(.ADDR_WIDTH(ADDR_WIDTH), .MAX_GAP(MAX_GAP)) u_issuer (
        .clk(clk), .rstn(rstn), .lfsr_addr(lfsr_addr), .lfsr_step(lfsr_step), .pif(pif)
    );

    l2_tag_store #(.ADDR_WIDTH(ADDR_WIDTH), .SET_BITS(SET_BITS)) u_store (
        .clk(clk), .rstn(rstn), .pif(pif),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_kind(wb_kind),
        .wb_ack(wb_ack), .wb_dat(wb_dat)
    );

    assign pref_valid = pif.valid;
    assign pref_kind  = pif.kind;
    assign pref_addr  = pif.addr;
    assign pref_done  = pif.done;
    assign pref_hit   = pif.hit;

endmodule

// ==== source/l2_tag_store.sv ====
`timescale 1ns/10ps

module l2_tag_store #(
    parameter int ADDR_WIDTH = 32,
    parameter int SET_BITS   = 3
) (
    input  logic                  clk,
    input  logic                  rstn,
    pref_if.store                 pif,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic [ADDR_WIDTH-1:0] wb_adr,
    input  pref_pkg::pref_kind_e  wb_kind,
    output logic                  wb_ack,
    output logic                  wb_dat
);
    import pref_pkg::*;
    import l2_cfg_pkg::*;

    localparam int TAG_W    = tag_bits(ADDR_WIDTH, SET_BITS);
    localparam int NUM_SETS = num_sets(SET_BITS);

    logic                  dem_req;
    logic                  dem_go;
    logic                  pf_go;
    logic                  op_go;
    logic [ADDR_WIDTH-1:0] op_addr;
    pref_kind_e            op_kind;
    logic                  op_bank;
    logic [TAG_W-1:0]      op_tag;
    logic [SET_BITS-1:0]   op_idx;
    logic                  op_hit;

    logic                  ack_q;
    logic                  done_q;
    logic                  hit_q;

    // per bank, 0 instruction and 1 data
    logic [NUM_SETS-1:0]   vld_q [2];
    logic [TAG_W-1:0]      tag_q [2][NUM_SETS];

    // --------------------------------------------------
    // arbitration, demand first
    // --------------------------------------------------

    assign dem_req = wb_cyc && wb_stb;

    // not re-served while its ack is out
    assign dem_go = dem_req && !ack_q;

    // prefetch waits as long as the demand master holds stb
    assign pf_go = pif.valid && !done_q && !dem_req;

    assign op_go   = dem_go || pf_go;
    assign op_addr = dem_go ? wb_adr : pif.addr;
    assign op_kind = dem_go ? wb_kind : pif.kind;

    // --------------------------------------------------
    // lookup
    // --------------------------------------------------

    assign op_bank = (op_kind == PREF_DATA);
    assign op_tag  = op_addr[ADDR_WIDTH-1 -: TAG_W];
    assign op_idx  = op_addr[LINE_OFFSET_BITS +: SET_BITS];
    assign op_hit  = vld_q[op_bank][op_idx] && (tag_q[op_bank][op_idx] == op_tag);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ack_q    <= 1'b0;
            done_q   <= 1'b0;
            hit_q    <= 1'b0;
            vld_q[0] <= '0;
            vld_q[1] <= '0;
        end else begin
            ack_q  <= dem_go;
            done_q <= pf_go;
            hit_q  <= op_go && op_hit;
            // install on miss
            if (op_go && !op_hit) begin
                vld_q[op_bank][op_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_go && !op_hit) begin
            tag_q[op_bank][op_idx] <= op_tag;
        end
    end

    assign wb_ack   = ack_q;
    assign wb_dat   = hit_q;
    assign pif.done = done_q;
    assign pif.hit  = hit_q;

    // one lookup per cycle so completions never overlap
    a_ack_done_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(wb_ack && pif.done));

    a_ack_pulse: assert property (@(posedge clk) disable iff (!rstn)
        wb_ack |=> !wb_ack);

endmodule

// ==== source/pref_if.sv ====
`timescale 1ns/10ps

interface pref_if #(
    parameter int ADDR_WIDTH = 32
);
    import pref_pkg::*;

    // request side, held until done
    logic                  valid;
    pref_kind_e            kind;
    logic [ADDR_WIDTH-1:0] addr;

    // completion pulse, hit qualified by done
    logic                  done;
    logic                  hit;

    modport issuer (
        output valid, kind, addr,
        input  done, hit
    );

    modport store (
        input  valid, kind, addr,
        output done, hit
    );

endinterface

// ==== source/pref_pkg.sv ====
package pref_pkg;

    // --------------------------------------------------
    // prefetch request types
    // --------------------------------------------------

    // bank select for the L2 tag store
    typedef enum logic {
        PREF_INSTR = 1'b0,
        PREF_DATA  = 1'b1
    } pref_kind_e;

    // issuer FSM
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        REQ  = 2'd1
    } pref_state_e;

    // idle gap counter and target width
    localparam int GAP_W = 4;

endpackage

// ==== source/prefetch_issuer.sv ====
`timescale 1ns/10ps

module prefetch_issuer #(
    parameter int ADDR_WIDTH = 32,
    parameter int MAX_GAP    = 10
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [ADDR_WIDTH-1:0] lfsr_addr,
    output logic                  lfsr_step,
    pref_if.issuer                pif
);
    import pref_pkg::*;

    pref_state_e           state_q;
    pref_state_e           state_d;
    logic [GAP_W-1:0]      target_q;
    logic [GAP_W-1:0]      count_q;
    logic [GAP_W-1:0]      count_inc;
    logic                  gap_done;
    pref_kind_e            kind_q;
    logic [ADDR_WIDTH-1:0] addr_q;

    // --------------------------------------------------
    // idle gap
    // --------------------------------------------------

    assign count_inc = count_q + 1'b1;

    // last idle cycle of the current gap
    assign gap_done = (state_q == IDLE) && (count_inc == target_q);

    // one step per request, address taken at the same edge
    assign lfsr_step = gap_done;

    // --------------------------------------------------
    // request FSM
    // --------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (gap_done) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                if (pif.done) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q  <= IDLE;
            target_q <= GAP_W'(1);
            count_q  <= '0;
            kind_q   <= PREF_INSTR;
        end else begin
            state_q <= state_d;
            // counter frozen while a request is out
            if (state_q == IDLE) begin
                count_q <= gap_done ? '0 : count_inc;
            end
            if (state_q == REQ && pif.done) begin
                kind_q   <= (kind_q == PREF_INSTR) ? PREF_DATA : PREF_INSTR;
                target_q <= (target_q == GAP_W'(MAX_GAP)) ? GAP_W'(1) : target_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (gap_done) begin
            addr_q <= lfsr_addr;
        end
    end

    assign pif.valid = (state_q == REQ);
    assign pif.kind  = kind_q;
    assign pif.addr  = addr_q;

    // request held stable until the store completes it
    a_req_stable: assert property (@(posedge clk) disable iff (!rstn)
        pif.valid && !pif.done |=> $stable(pif.addr) && $stable(pif.kind));

    a_valid_drops: assert property (@(posedge clk) disable iff (!rstn)
        pif.valid && pif.done |=> !pif.valid);

endmodule

// ==== verif/tb_l2_prefetch.sv ====
`timescale 1ns/10ps

module tb_l2_prefetch;
    import pref_pkg::*;

    localparam int ADDR_WIDTH  = 32;
    localparam int SET_BITS    = 3;
    localparam int MAX_GAP     = 10;
    localparam int OFFSET_BITS = 5;
    localparam int TAG_W       = ADDR_WIDTH - SET_BITS - OFFSET_BITS;
    // cycle budget per test, in run order
    localparam int BUDGET      = 20 + 110 + 50 + 30 + 20 + 50;

    logic                  clk;
    logic                  rstn;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic [ADDR_WIDTH-1:0] wb_adr;
    pref_kind_e            wb_kind;
    logic                  wb_ack;
    logic                  wb_dat;
    logic                  pref_valid;
    pref_kind_e            pref_kind;
    logic [ADDR_WIDTH-1:0] pref_addr;
    logic                  pref_done;
    logic                  pref_hit;

    int                    errors = 0;
    int                    checks = 0;
    int                    failed_tests = 0;
    int                    ack_count = 0;
    logic [31:0]           rnd = 32'h5d87;
    // reference model
    logic [31:0]           model_lfsr = 32'd1;
    pref_kind_e            model_kind = PREF_INSTR;
    logic [(1<<SET_BITS)-1:0] sh_vld [2];
    logic [TAG_W-1:0]      sh_tag [2][1<<SET_BITS];
    // prefetch completions seen by the monitor
    logic [ADDR_WIDTH-1:0] rec_addr [$];
    pref_kind_e            rec_kind [$];
    logic                  rec_hit [$];
    logic                  rec_exp [$];
    // demand stream and what happened during it
    logic [ADDR_WIDTH-1:0] dq_addr [$];
    pref_kind_e            dq_kind [$];
    logic                  dq_hit [$];
    int                    busy_dones;
    int                    addr_moves;
    logic                  held_ok;
    logic [ADDR_WIDTH-1:0] held_addr;

    l2_prefetch_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // model and helpers
    // --------------------------------------------------

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rnd = lfsr_next(rnd);
            v = {v[30:0], rnd[0]};
        end
        return v;
    endfunction

    // direct-mapped lookup, installs on miss
    function automatic logic model_lookup(input logic [ADDR_WIDTH-1:0] a, input pref_kind_e k);
        logic                b;
        logic [SET_BITS-1:0] idx;
        logic [TAG_W-1:0]    tag;
        logic                hit;
        b   = (k == PREF_DATA);
        idx = a[OFFSET_BITS +: SET_BITS];
        tag = a[ADDR_WIDTH-1 -: TAG_W];
        hit = sh_vld[b][idx] && (sh_tag[b][idx] == tag);
        if (!hit) begin
            sh_vld[b][idx] = 1'b1;
            sh_tag[b][idx] = tag;
        end
        return hit;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("%-12s ok", name);
        end else begin
            failed_tests++;
            $display("%-12s FAILED with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!pref_done) @(negedge clk);
    endtask

    // compare recorded prefetches against the model LFSR, kind toggle and shadow tags
    task automatic drain_records(input string name);
        @(posedge clk);
        while (rec_addr.size() > 0) begin
            compare_value({name, " addr"}, {model_lfsr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}},
                          rec_addr.pop_front());
            model_lfsr = lfsr_next(model_lfsr);
            compare_value({name, " kind"}, model_kind, rec_kind.pop_front());
            model_kind = (model_kind == PREF_INSTR) ? PREF_DATA : PREF_INSTR;
            compare_value({name, " hit"}, rec_exp.pop_front(), rec_hit.pop_front());
        end
    endtask

    task automatic add_demand(input logic [ADDR_WIDTH-1:0] a, input pref_kind_e k);
        dq_addr.push_back(a);
        dq_kind.push_back(k);
    endtask

    // stb stays high across the whole stream, each ack ends one access
    task automatic run_demands();
        dq_hit.delete();
        busy_dones = 0;
        addr_moves = 0;
        held_ok    = 1'b0;
        foreach (dq_addr[i]) begin
            @(posedge clk);
            wb_cyc  <= 1'b1;
            wb_stb  <= 1'b1;
            wb_adr  <= dq_addr[i];
            wb_kind <= dq_kind[i];
            do begin
                @(negedge clk);
                if (pref_done) busy_dones++;
                if (pref_valid && !held_ok) begin
                    held_addr = pref_addr;
                    held_ok   = 1'b1;
                end else if (pref_valid && pref_addr !== held_addr) begin
                    addr_moves++;
                end
            end while (!wb_ack);
            dq_hit.push_back(wb_dat);
            void'(model_lookup(dq_addr[i], dq_kind[i]));
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        dq_addr.delete();
        dq_kind.delete();
    endtask

    // passive monitor
    initial begin
        forever begin
            @(negedge clk);
            if (rstn && wb_ack) ack_count++;
            if (rstn && pref_done) begin
                rec_addr.push_back(pref_addr);
                rec_kind.push_back(pref_kind);
                rec_hit.push_back(pref_hit);
                rec_exp.push_back(model_lookup(pref_addr, pref_kind));
            end
        end
    end

    // --------------------------------------------------
    // tests
    // --------------------------------------------------

    task automatic reset_and_first_request();
        int e;
        e = errors;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        compare_value("reset pref_valid", 0, pref_valid);
        compare_value("reset pref_done", 0, pref_done);
        compare_value("reset wb_ack", 0, wb_ack);
        compare_value("reset pref_hit", 0, pref_hit);
        @(negedge clk);
        compare_value("first gap", 1, pref_valid);
        report_test("reset", e);
    endtask

    task automatic gap_and_kind();
        int e;
        int idle;
        int tgt;
        e   = errors;
        tgt = 1;
        repeat (12) begin
            wait_done();
            tgt  = (tgt == MAX_GAP) ? 1 : tgt + 1;
            idle = 0;
            @(negedge clk);
            while (!pref_valid) begin
                idle++;
                @(negedge clk);
            end
            compare_value("gap length", tgt, idle);
        end
        drain_records("gap_kind");
        report_test("gap_kind", e);
    endtask

    task automatic prefetch_addresses();
        int                    e;
        logic [ADDR_WIDTH-1:0] a;
        e = errors;
        repeat (3) begin
            @(negedge clk);
            while (pref_valid) @(negedge clk);
            while (!pref_valid) @(negedge clk);
            a = pref_addr;
            while (!pref_done) begin
                @(negedge clk);
                compare_value("addr held", a, pref_addr);
            end
        end
        drain_records("addresses");
        report_test("addresses", e);
    endtask

    task automatic prefetch_install();
        int                    e;
        logic [ADDR_WIDTH-1:0] a;
        pref_kind_e            k;
        e = errors;
        wait_done();
        a = pref_addr;
        k = pref_kind;
        add_demand(a, k);
        add_demand(a, (k == PREF_INSTR) ? PREF_DATA : PREF_INSTR);
        run_demands();
        compare_value("install same kind", 1, dq_hit[0]);
        compare_value("install other kind", 0, dq_hit[1]);
        drain_records("install");
        report_test("install", e);
    endtask

    task automatic demand_conflict();
        int                    e;
        logic [ADDR_WIDTH-1:0] a;
        logic [ADDR_WIDTH-1:0] b;
        pref_kind_e            k;
        e = errors;
        a = rand_bits(ADDR_WIDTH);
        a = {a[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        // same index, top tag bit flipped
        b = a ^ (32'd1 << (ADDR_WIDTH - 1));
        k = pref_kind_e'(rand_bits(1));
        add_demand(a, k);
        add_demand(a, k);
        add_demand(b, k);
        add_demand(a, k);
        run_demands();
        compare_value("demand first", 0, dq_hit[0]);
        compare_value("demand again", 1, dq_hit[1]);
        compare_value("conflict", 0, dq_hit[2]);
        compare_value("evicted", 0, dq_hit[3]);
        drain_records("conflict");
        report_test("conflict", e);
    endtask

    task automatic demand_backpressure();
        int          e;
        int          acks;
        logic [31:0] a;
        e = errors;
        wait_done();
        acks = ack_count;
        repeat (12) begin
            a = rand_bits(ADDR_WIDTH);
            add_demand({a[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}}, pref_kind_e'(rand_bits(1)));
        end
        run_demands();
        if (!held_ok) begin
            errors++;
            $display("backpressure: no prefetch request was pending during the demand stream");
        end
        compare_value("done while busy", 0, busy_dones);
        compare_value("addr moved", 0, addr_moves);
        wait_done();
        compare_value("addr at done", held_addr, pref_addr);
        compare_value("ack count", 12, ack_count - acks);
        drain_records("backpressure");
        report_test("backpressure", e);
    endtask

    initial begin
        rstn      = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_adr    = '0;
        wb_kind   = PREF_INSTR;
        sh_vld[0] = '0;
        sh_vld[1] = '0;
        reset_and_first_request();
        gap_and_kind();
        prefetch_addresses();
        prefetch_install();
        demand_conflict();
        demand_backpressure();
        $display("tests 6, failed %0d, checks %0d, errors %0d", failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (2 * BUDGET) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", 2 * BUDGET);
        $display("Simulation failed");
        $finish;
    end

endmodule
